// ==== hdl/backendPkg.sv ====
package backendPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN   = 32;
    localparam int AREG_W = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_PASSB = 3'd5  // lui forwards operand b.
    } aluOp_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encoding fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;

    localparam logic [2:0] F3_ADD = 3'b000;  // also sub.
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects sub.

endpackage

// ==== hdl/decode.sv ====
`timescale 1ns/1ps

module decode import backendPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              instValid,
    input  logic [31:0]       inst,
    input  logic              stall,
    output logic              decValid,
    output aluOp_e            decOp,
    output logic [AREG_W-1:0] decRs1,
    output logic [AREG_W-1:0] decRs2,
    output logic [AREG_W-1:0] decRd,
    output logic              decWe,
    output logic              decUseImm,
    output logic [XLEN-1:0]   decImm
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    aluOp_e          op;
    logic            known;
    logic            useImm;
    logic [XLEN-1:0] imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op     = ALU_ADD;
        known  = 1'b0;
        useImm = 1'b0;
        imm    = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            OPC_RTYPE: begin
                known = (funct7 == F7_BASE) || (funct3 == F3_ADD && funct7 == F7_ALT);
                case (funct3)
                    F3_ADD:  op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_AND:  op = ALU_AND;
                    F3_OR:   op = ALU_OR;
                    F3_XOR:  op = ALU_XOR;
                    default: known = 1'b0;
                endcase
            end
            OPC_ITYPE: begin
                useImm = 1'b1;
                known  = 1'b1;
                case (funct3)
                    F3_ADD:  op = ALU_ADD;
                    F3_AND:  op = ALU_AND;
                    F3_OR:   op = ALU_OR;
                    F3_XOR:  op = ALU_XOR;
                    default: known = 1'b0;
                endcase
            end
            OPC_LUI: begin
                known  = 1'b1;
                useImm = 1'b1;
                op     = ALU_PASSB;
                imm    = {inst[31:12], 12'b0};
            end
            default: known = 1'b0;  // retires without writing.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (!stall) begin
            decValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decOp     <= op;
            decRs1    <= (known && opcode != OPC_LUI) ? inst[19:15] : '0;
            decRs2    <= (known && opcode == OPC_RTYPE) ? inst[24:20] : '0;
            decRd     <= inst[11:7];
            decWe     <= known && (inst[11:7] != '0);
            decUseImm <= useImm;
            decImm    <= imm;
        end
    end

endmodule

// ==== hdl/rename.sv ====
`timescale 1ns/1ps

module rename import backendPkg::*; #(
    parameter int  PREG_NUM = 64,
    localparam int TAG_W    = $clog2(PREG_NUM)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  logic [AREG_W-1:0] decRs1,
    input  logic [AREG_W-1:0] decRs2,
    input  logic [AREG_W-1:0] decRd,
    input  logic              decWe,
    input  logic              wakeValid,
    input  logic [TAG_W-1:0]  wakeTag,
    input  logic              freeValid,
    input  logic [TAG_W-1:0]  freePrd,
    output logic [TAG_W-1:0]  psrc1,
    output logic [TAG_W-1:0]  psrc2,
    output logic [TAG_W-1:0]  prd,
    output logic [TAG_W-1:0]  oldPrd,
    output logic              src1Ready,
    output logic              src2Ready,
    output logic              full
);
    localparam int CNT_W = $clog2(PREG_NUM + 1);

    logic [TAG_W-1:0]    rat      [32];
    logic [TAG_W-1:0]    freeList [PREG_NUM];
    logic [TAG_W-1:0]    flHead;
    logic [TAG_W-1:0]    flTail;
    logic [CNT_W-1:0]    flCount;
    logic [PREG_NUM-1:0] busy;
    logic                alloc;

    assign alloc  = dispatch && decWe;
    assign psrc1  = rat[decRs1];
    assign psrc2  = rat[decRs2];
    assign oldPrd = rat[decRd];
    assign prd    = decWe ? freeList[flHead] : '0;  // non-writers keep p0.
    assign full   = (flCount == '0);

    // same-cycle wakeup bypass.
    assign src1Ready = !busy[psrc1] || (wakeValid && wakeTag == psrc1);
    assign src2Ready = !busy[psrc2] || (wakeValid && wakeTag == psrc2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alias table, free list and busy bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rat[i] <= TAG_W'(i);  // identity map.
            end
            for (int i = 0; i < PREG_NUM; i++) begin
                freeList[i] <= TAG_W'(i);
            end
            flHead  <= TAG_W'(32);
            flTail  <= '0;
            flCount <= CNT_W'(PREG_NUM - 32);
            busy    <= '0;
        end else begin
            if (wakeValid) begin
                busy[wakeTag] <= 1'b0;
            end
            if (alloc) begin
                rat[decRd] <= prd;
                busy[prd]  <= 1'b1;
                flHead     <= (flHead == TAG_W'(PREG_NUM - 1)) ? '0 : flHead + 1'b1;
            end
            if (freeValid) begin
                freeList[flTail] <= freePrd;
                flTail           <= (flTail == TAG_W'(PREG_NUM - 1)) ? '0 : flTail + 1'b1;
            end
            flCount <= flCount + CNT_W'(freeValid) - CNT_W'(alloc);
        end
    end

endmodule

// ==== hdl/rob.sv ====
`timescale 1ns/1ps

module rob import backendPkg::*; #(
    parameter int  ROB_SIZE = 16,
    parameter int  PREG_NUM = 64,
    localparam int IDX_W    = $clog2(ROB_SIZE),
    localparam int TAG_W    = $clog2(PREG_NUM)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  logic [AREG_W-1:0] decRd,
    input  logic              decWe,
    input  logic [TAG_W-1:0]  oldPrd,
    input  logic              wbValid,
    input  logic [IDX_W-1:0]  wbRobIdx,
    input  logic [XLEN-1:0]   wbData,
    output logic [IDX_W-1:0]  robIdx,
    output logic              full,
    output logic              commitEn,
    output logic              commitWe,
    output logic [AREG_W-1:0] commitRd,
    output logic [XLEN-1:0]   commitData,
    output logic              freeValid,
    output logic [TAG_W-1:0]  freePrd
);
    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    logic [AREG_W-1:0]   entRd     [ROB_SIZE];
    logic                entWe     [ROB_SIZE];
    logic [TAG_W-1:0]    entOldPrd [ROB_SIZE];
    logic [XLEN-1:0]     entData   [ROB_SIZE];
    logic [ROB_SIZE-1:0] entDone;
    logic [IDX_W-1:0]    head;
    logic [IDX_W-1:0]    tail;
    logic [CNT_W-1:0]    count;

    assign robIdx = tail;
    assign full   = (count == CNT_W'(ROB_SIZE));

    // head retires as soon as its result is in.
    assign commitEn   = (count != '0) && entDone[head];
    assign commitWe   = entWe[head];
    assign commitRd   = entRd[head];
    assign commitData = entData[head];
    assign freeValid  = commitEn && entWe[head];
    assign freePrd    = entOldPrd[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            entDone <= '0;
        end else begin
            if (wbValid) begin
                entDone[wbRobIdx] <= 1'b1;
            end
            if (dispatch) begin
                entDone[tail] <= 1'b0;
                tail          <= (tail == IDX_W'(ROB_SIZE - 1)) ? '0 : tail + 1'b1;
            end
            if (commitEn) begin
                head <= (head == IDX_W'(ROB_SIZE - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(dispatch) - CNT_W'(commitEn);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            entRd[tail]     <= decRd;
            entWe[tail]     <= decWe;
            entOldPrd[tail] <= oldPrd;
        end
        if (wbValid) begin
            entData[wbRobIdx] <= wbData;
        end
    end

endmodule

// ==== hdl/intIssueQueue.sv ====
`timescale 1ns/1ps

module intIssueQueue import backendPkg::*; #(
    parameter int  IQ_SIZE  = 8,
    parameter int  PREG_NUM = 64,
    parameter int  ROB_SIZE = 16,
    localparam int TAG_W    = $clog2(PREG_NUM),
    localparam int IDX_W    = $clog2(ROB_SIZE)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch,
    input  aluOp_e           decOp,
    input  logic             decUseImm,
    input  logic [XLEN-1:0]  decImm,
    input  logic             decWe,
    input  logic [TAG_W-1:0] psrc1,
    input  logic [TAG_W-1:0] psrc2,
    input  logic [TAG_W-1:0] prd,
    input  logic             src1Ready,
    input  logic             src2Ready,
    input  logic [IDX_W-1:0] robIdx,
    output logic             full,
    output logic             wakeValid,
    output logic [TAG_W-1:0] wakeTag,
    output logic             issValid,
    output aluOp_e           issOp,
    output logic [TAG_W-1:0] issPsrc1,
    output logic [TAG_W-1:0] issPsrc2,
    output logic [TAG_W-1:0] issPrd,
    output logic             issWe,
    output logic             issUseImm,
    output logic [XLEN-1:0]  issImm,
    output logic [IDX_W-1:0] issRobIdx
);
    localparam int SLOT_W = $clog2(IQ_SIZE);
    localparam int SEQ_W  = 8;  // wider than the in-flight window.

    logic [IQ_SIZE-1:0] slotValid;
    aluOp_e             slotOp     [IQ_SIZE];
    logic               slotUseImm [IQ_SIZE];
    logic [XLEN-1:0]    slotImm    [IQ_SIZE];
    logic               slotWe     [IQ_SIZE];
    logic [TAG_W-1:0]   slotPsrc1  [IQ_SIZE];
    logic [TAG_W-1:0]   slotPsrc2  [IQ_SIZE];
    logic [TAG_W-1:0]   slotPrd    [IQ_SIZE];
    logic               slotRdy1   [IQ_SIZE];
    logic               slotRdy2   [IQ_SIZE];
    logic [IDX_W-1:0]   slotRobIdx [IQ_SIZE];
    logic [SEQ_W-1:0]   slotSeq    [IQ_SIZE];
    logic [SEQ_W-1:0]   seqNext;
    logic               selFound;
    logic [SLOT_W-1:0]  selIdx;
    logic [SLOT_W-1:0]  freeIdx;

    assign full = &slotValid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // oldest-ready select and free slot search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        logic [SEQ_W-1:0] ageDiff;
        selFound = 1'b0;
        selIdx   = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            ageDiff = slotSeq[i] - slotSeq[selIdx];
            if (slotValid[i] && slotRdy1[i] && slotRdy2[i] && (!selFound || ageDiff[SEQ_W-1])) begin
                selFound = 1'b1;
                selIdx   = SLOT_W'(i);
            end
        end
    end

    always_comb begin
        freeIdx = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (!slotValid[i]) begin
                freeIdx = SLOT_W'(i);  // lowest free slot wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
            seqNext   <= '0;
            issValid  <= 1'b0;
            wakeValid <= 1'b0;
        end else begin
            issValid  <= selFound;
            wakeValid <= selFound && slotWe[selIdx];  // only writers broadcast.
            if (selFound) begin
                slotValid[selIdx] <= 1'b0;
            end
            if (dispatch) begin
                slotValid[freeIdx] <= 1'b1;
                seqNext            <= seqNext + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (wakeValid && slotPsrc1[i] == wakeTag) slotRdy1[i] <= 1'b1;
            if (wakeValid && slotPsrc2[i] == wakeTag) slotRdy2[i] <= 1'b1;
        end
        if (dispatch) begin
            slotOp[freeIdx]     <= decOp;
            slotUseImm[freeIdx] <= decUseImm;
            slotImm[freeIdx]    <= decImm;
            slotWe[freeIdx]     <= decWe;
            slotPsrc1[freeIdx]  <= psrc1;
            slotPsrc2[freeIdx]  <= psrc2;
            slotPrd[freeIdx]    <= prd;
            slotRdy1[freeIdx]   <= src1Ready;
            slotRdy2[freeIdx]   <= src2Ready;
            slotRobIdx[freeIdx] <= robIdx;
            slotSeq[freeIdx]    <= seqNext;
        end
        wakeTag   <= slotPrd[selIdx];
        issOp     <= slotOp[selIdx];
        issPsrc1  <= slotPsrc1[selIdx];
        issPsrc2  <= slotPsrc2[selIdx];
        issPrd    <= slotPrd[selIdx];
        issWe     <= slotWe[selIdx];
        issUseImm <= slotUseImm[selIdx];
        issImm    <= slotImm[selIdx];
        issRobIdx <= slotRobIdx[selIdx];
    end

endmodule

// ==== hdl/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute import backendPkg::*; #(
    parameter int  PREG_NUM = 64,
    parameter int  ROB_SIZE = 16,
    localparam int TAG_W    = $clog2(PREG_NUM),
    localparam int IDX_W    = $clog2(ROB_SIZE)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issValid,
    input  aluOp_e           issOp,
    input  logic [TAG_W-1:0] issPsrc1,
    input  logic [TAG_W-1:0] issPsrc2,
    input  logic [TAG_W-1:0] issPrd,
    input  logic             issWe,
    input  logic             issUseImm,
    input  logic [XLEN-1:0]  issImm,
    input  logic [IDX_W-1:0] issRobIdx,
    output logic             wbValid,
    output logic [IDX_W-1:0] wbRobIdx,
    output logic [XLEN-1:0]  wbData
);
    logic [XLEN-1:0] regFile [PREG_NUM];
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] result;

    assign opA = regFile[issPsrc1];
    assign opB = issUseImm ? issImm : regFile[issPsrc2];

    always_comb begin
        case (issOp)
            ALU_ADD:   result = opA + opB;
            ALU_SUB:   result = opA - opB;
            ALU_AND:   result = opA & opB;
            ALU_OR:    result = opA | opB;
            ALU_XOR:   result = opA ^ opB;
            ALU_PASSB: result = opB;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            for (int i = 0; i < PREG_NUM; i++) begin
                regFile[i] <= '0;  // architectural state starts at zero.
            end
        end else begin
            wbValid <= issValid;
            if (issValid && issWe && issPrd != '0) begin
                regFile[issPrd] <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        wbRobIdx <= issRobIdx;
        wbData   <= result;
    end

endmodule

// ==== hdl/backend.sv ====
`timescale 1ns/1ps

module backend import backendPkg::*; #(
    parameter int PREG_NUM = 64,
    parameter int ROB_SIZE = 16,
    parameter int IQ_SIZE  = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instValid,
    input  logic [31:0]       inst,
    output logic              stall,
    output logic              commitEn,
    output logic              commitWe,
    output logic [AREG_W-1:0] commitRd,
    output logic [XLEN-1:0]   commitData
);
    localparam int TAG_W = $clog2(PREG_NUM);
    localparam int IDX_W = $clog2(ROB_SIZE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic              decValid, decWe, decUseImm;
    aluOp_e            decOp;
    logic [AREG_W-1:0] decRs1, decRs2, decRd;
    logic [XLEN-1:0]   decImm;
    logic              dispatch, renameFull, robFull, iqFull;
    logic [TAG_W-1:0]  psrc1, psrc2, prd, oldPrd;
    logic              src1Ready, src2Ready;
    logic [IDX_W-1:0]  robIdx;
    logic              wakeValid, freeValid;
    logic [TAG_W-1:0]  wakeTag, freePrd;
    logic              issValid, issWe, issUseImm;
    aluOp_e            issOp;
    logic [TAG_W-1:0]  issPsrc1, issPsrc2, issPrd;
    logic [XLEN-1:0]   issImm;
    logic [IDX_W-1:0]  issRobIdx;
    logic              wbValid;
    logic [IDX_W-1:0]  wbRobIdx;
    logic [XLEN-1:0]   wbData;

    assign stall    = renameFull | robFull | iqFull;
    assign dispatch = decValid & ~stall;

    decode u_decode (.*);

    rename #(.PREG_NUM(PREG_NUM)) u_rename (.*, .full(renameFull));

    rob #(.ROB_SIZE(ROB_SIZE), .PREG_NUM(PREG_NUM)) u_rob (.*, .full(robFull));

    intIssueQueue #(
        .IQ_SIZE(IQ_SIZE),
        .PREG_NUM(PREG_NUM),
        .ROB_SIZE(ROB_SIZE)
    ) u_intIssueQueue (
        .*,
        .full(iqFull)
    );

    aluExecute #(.PREG_NUM(PREG_NUM), .ROB_SIZE(ROB_SIZE)) u_aluExecute (.*);

endmodule

// ==== verif/backendTb.sv ====
`timescale 1ns/1ps

module backendTb;

    localparam int ROB_SIZE     = 16;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int N_DIRECTED   = 32;  // upper bound over tests 2 to 4.
    localparam int N_BURST      = ROB_SIZE + 8;
    localparam int N_RAND       = 200;
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * IDLE_CYCLES
                                + 40 * (N_DIRECTED + N_BURST + N_RAND);

    localparam logic [6:0]  R_OP = 7'b0110011;
    localparam logic [6:0]  I_OP = 7'b0010011;
    localparam logic [6:0]  U_OP = 7'b0110111;
    localparam logic [31:0] TAPS = 32'h80200003;

    logic        clk;
    logic        rst;
    logic        instValid;
    logic [31:0] inst;
    logic        stall;
    logic        commitEn;
    logic        commitWe;
    logic [4:0]  commitRd;
    logic [31:0] commitData;

    logic [31:0] arch [32];  // architectural values in program order.
    logic [37:0] expQ [$];   // {we, rd, data} per accepted instruction.
    logic [37:0] expHead;
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          stallCycles;
    int          cycles;

    backend #(.PREG_NUM(64), .ROB_SIZE(ROB_SIZE), .IQ_SIZE(8)) u_dut (
        .clk        (clk),
        .rst        (rst),
        .instValid  (instValid),
        .inst       (inst),
        .stall      (stall),
        .commitEn   (commitEn),
        .commitWe   (commitWe),
        .commitRd   (commitRd),
        .commitData (commitData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb       = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (lsb ? TAPS : 32'h0);
            val       = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, R_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, I_OP};
    endfunction

    function automatic logic [31:0] encU(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, U_OP};
    endfunction

    task automatic flagProblem(input string msg);
        errorCount++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // reference model step for one instruction in program order.
    task automatic expectInst(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] val;
        logic        known;
        logic        we;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        rd    = w[11:7];
        a     = arch[w[19:15]];
        b     = arch[w[24:20]];
        immI  = {{20{w[31]}}, w[31:20]};
        val   = '0;
        known = 1'b1;
        if (opc == R_OP && f7 == 7'h00) begin
            case (f3)
                3'd0: val = a + b;
                3'd4: val = a ^ b;
                3'd6: val = a | b;
                3'd7: val = a & b;
                default: known = 1'b0;
            endcase
        end else if (opc == R_OP && f7 == 7'h20 && f3 == 3'd0) begin
            val = a - b;
        end else if (opc == I_OP) begin
            case (f3)
                3'd0: val = a + immI;
                3'd4: val = a ^ immI;
                3'd6: val = a | immI;
                3'd7: val = a & immI;
                default: known = 1'b0;
            endcase
        end else if (opc == U_OP) begin
            val = {w[31:12], 12'h000};
        end else begin
            known = 1'b0;
        end
        we = known && (rd != 5'd0);
        if (we) begin
            arch[rd] = val;
        end
        expQ.push_back({we, rd, val});
    endtask

    // holds the word on the inputs until a cycle without stall takes it.
    task automatic sendInst(input logic [31:0] word);
        logic taken;
        instValid = 1'b1;
        inst      = word;
        taken     = 1'b0;
        while (!taken) begin
            if (stall) begin
                stallCycles++;
            end else begin
                taken = 1'b1;
                expectInst(word);
            end
            @(negedge clk);
        end
        instValid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic waitCommits();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic endTest(input string name, input int errsAtStart);
        testCount++;
        if (errorCount == errsAtStart) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errorCount - errsAtStart);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit checker and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst && commitEn) begin
            if (expQ.size() == 0) begin
                flagProblem("commit seen with no instruction outstanding");
            end else begin
                expHead = expQ.pop_front();
                checkCount++;
                if (commitWe !== expHead[37] || commitRd !== expHead[36:32]
                        || (expHead[37] && commitData !== expHead[31:0])) begin
                    errorCount++;
                    $display("FAILED %0t: commit we=%0b rd=%0d data=%08h, expected %0b %0d %08h",
                             $time, commitWe, commitRd, commitData,
                             expHead[37], expHead[36:32], expHead[31:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkIdle();
        int errs;
        errs = errorCount;
        repeat (IDLE_CYCLES) begin
            checkCount++;
            if (stall !== 1'b0 || commitEn !== 1'b0) begin
                errorCount++;
                $display("FAILED %0t: stall=%b commitEn=%b while idle", $time, stall, commitEn);
            end
            @(negedge clk);
        end
        endTest("idleAfterReset", errs);
    endtask

    task automatic checkEachOp();
        int errs;
        errs = errorCount;
        sendInst(encU(5'd1, 20'h8badf));
        sendInst(encI(3'd0, 5'd2, 5'd0, 12'hff9));  // negative immediate.
        sendInst(encI(3'd6, 5'd3, 5'd0, 12'h7ff));
        sendInst(encI(3'd4, 5'd4, 5'd1, 12'h800));
        sendInst(encI(3'd7, 5'd8, 5'd2, 12'h0f0));
        sendInst(encR(7'h00, 3'd0, 5'd10, 5'd1, 5'd2));
        sendInst(encR(7'h20, 3'd0, 5'd11, 5'd2, 5'd1));
        sendInst(encR(7'h00, 3'd7, 5'd12, 5'd2, 5'd4));
        sendInst(encR(7'h00, 3'd6, 5'd13, 5'd3, 5'd1));
        sendInst(encR(7'h00, 3'd4, 5'd14, 5'd2, 5'd3));
        sendInst(encI(3'd0, 5'd15, 5'd3, 12'h001));
        waitCommits();
        endTest("eachOpcode", errs);
    endtask

    task automatic checkChains();
        int errs;
        errs = errorCount;
        sendInst(encI(3'd0, 5'd5, 5'd0, 12'h003));
        repeat (3) sendInst(encR(7'h00, 3'd0, 5'd5, 5'd5, 5'd5));
        sendInst(encR(7'h20, 3'd0, 5'd6, 5'd5, 5'd2));
        sendInst(encR(7'h00, 3'd4, 5'd7, 5'd6, 5'd5));
        sendInst(encR(7'h00, 3'd7, 5'd9, 5'd7, 5'd6));
        sendInst(encR(7'h00, 3'd6, 5'd9, 5'd9, 5'd1));
        sendInst(encI(3'd0, 5'd9, 5'd9, 12'hfff));
        sendInst(encU(5'd5, 20'h00012));  // fresh mapping for x5.
        sendInst(encI(3'd0, 5'd5, 5'd5, 12'h345));
        waitCommits();
        endTest("dependentChains", errs);
    endtask

    task automatic checkZeroReg();
        int errs;
        errs = errorCount;
        sendInst(encR(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
        sendInst(encI(3'd0, 5'd0, 5'd0, 12'h123));
        sendInst(encU(5'd0, 20'habcde));
        sendInst(encR(7'h00, 3'd0, 5'd6, 5'd0, 5'd0));
        sendInst(encI(3'd4, 5'd7, 5'd0, 12'hfff));
        sendInst(encR(7'h00, 3'd6, 5'd8, 5'd0, 5'd0));
        waitCommits();
        endTest("zeroRegister", errs);
    endtask

    task automatic checkBurst();
        int errs;
        int stallsBefore;
        errs         = errorCount;
        stallsBefore = stallCycles;
        sendInst(encU(5'd20, 20'h40000));
        for (int i = 1; i < N_BURST; i++) begin
            sendInst(encI(3'd0, 5'd20, 5'd20, 12'(i)));
        end
        waitCommits();
        if (stallCycles == stallsBefore) begin
            flagProblem("stall never rose during the dependent burst");
        end
        endTest("dependentBurst", errs);
    endtask

    task automatic checkRandom();
        int          errs;
        logic [3:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] word;
        errs = errorCount;
        for (int n = 0; n < N_RAND; n++) begin
            sel = 4'(randBits(4));
            rd  = 5'(randBits(3));  // x0..x7 keeps dependencies dense.
            rs1 = 5'(randBits(3));
            rs2 = 5'(randBits(3));
            imm = 12'(randBits(12));
            case (sel)
                4'd0: word = encR(7'h00, 3'd0, rd, rs1, rs2);
                4'd1: word = encR(7'h20, 3'd0, rd, rs1, rs2);
                4'd2: word = encR(7'h00, 3'd4, rd, rs1, rs2);
                4'd3: word = encR(7'h00, 3'd6, rd, rs1, rs2);
                4'd4: word = encR(7'h00, 3'd7, rd, rs1, rs2);
                4'd5: word = encI(3'd4, rd, rs1, imm);
                4'd6: word = encI(3'd6, rd, rs1, imm);
                4'd7: word = encI(3'd7, rd, rs1, imm);
                4'd8: word = encU(rd, 20'(randBits(20)));
                4'd9: word = {imm, rs1, 3'b010, rd, 7'b0000011};  // unsupported load.
                default: word = encI(3'd0, rd, rs1, imm);
            endcase
            sendInst(word);
            idle(int'(randBits(2)));
        end
        waitCommits();
        idle(IDLE_CYCLES);  // trailing window for stray commits.
        endTest("randomStream", errs);
    endtask

    initial begin
        rst         = 1'b1;
        instValid   = 1'b0;
        inst        = '0;
        lfsrState   = 32'h7d78b88a;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        stallCycles = 0;
        cycles      = 0;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkIdle();
        checkEachOp();
        checkChains();
        checkZeroReg();
        checkBurst();
        checkRandom();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== backend.f ====
hdl/backendPkg.sv
hdl/decode.sv
hdl/rename.sv
hdl/rob.sv
hdl/intIssueQueue.sv
hdl/aluExecute.sv
hdl/backend.sv
verif/backendTb.sv
